//--- verilog/frontend_cfg.svh
//////////////////////////////
// Front end configuration
// Widths, reset PC and sizes shared by the fetch blocks
//////////////////////////////

`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// Address and data width
`define FE_XLEN 32

// First fetch address after reset
`define FE_PC_INIT 'h200

// Fetch queue entries
`define FE_QUEUE_DEPTH 4

// Branch history table index bits
`define FE_BHT_IDX_W 6

`endif

//--- verilog/frontend_pkg.sv
//////////////////////////////
// Front end types
// Opcodes and the stream, redirect and training structs
//////////////////////////////

`default_nettype none

`include "frontend_cfg.svh"

package frontend_pkg;

  //////////////////////////////
  // Opcodes

  // Jump and link
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  // Conditional branches
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  // addi x0, x0, 0
  localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

  //////////////////////////////
  // Stream payloads

  // Raw instruction word, 32 bits
  typedef logic [31:0] instr_t;

  // Fetch request, 32 bits
  typedef struct packed {
    logic [`FE_XLEN-1:0] addr;
  } fetch_req_t;

  // Fetch response, 65 bits
  typedef struct packed {
    logic [`FE_XLEN-1:0] addr;
    instr_t              instr;
    // Bus access fault on this word
    logic                fault;
  } fetch_rsp_t;

  // Payload towards decode, 89 bits
  typedef struct packed {
    logic [`FE_XLEN-1:0] pc;
    instr_t              instr;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [11:0]         csr;
    logic                fault;
    // 10 for JAL, counter value for branches
    logic [1:0]          predict;
  } pd_out_t;

  //////////////////////////////
  // Control

  // PC redirect, 33 bits
  typedef struct packed {
    logic                valid;
    logic [`FE_XLEN-1:0] pc;
  } redirect_t;

  // Resolved branch from the back end, 34 bits
  typedef struct packed {
    logic                valid;
    logic [`FE_XLEN-1:0] pc;
    logic                taken;
  } bht_update_t;

endpackage

`default_nettype wire

//--- verilog/fetch_pc_gen.sv
//////////////////////////////
// Fetch PC generator
// Next fetch address, request issue and credit tracking
// Stale responses after a redirect are marked for drop
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "frontend_cfg.svh"

module fetch_pc_gen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Redirect sources, back end wins
  input  frontend_pkg::redirect_t  be_redirect_i,
  input  frontend_pkg::redirect_t  pd_redirect_i,
  // Request channel to instruction memory
  output frontend_pkg::fetch_req_t req_o,
  output logic                     req_valid_o,
  input  logic                     req_ready_i,
  // Queue side
  input  logic                     rsp_valid_i,
  input  logic                     q_pop_i,
  output logic                     q_flush_o,
  output logic                     q_drop_o
);

  localparam int unsigned CNT_W = $clog2(`FE_QUEUE_DEPTH + 1);
  localparam logic [`FE_XLEN-1:0] PC_INIT = `FE_PC_INIT;

  logic [`FE_XLEN-1:0] pc_q;
  // Held low through reset and the cycle after
  logic                fetch_en_q;
  // In flight plus queued entries
  logic [CNT_W-1:0]    credit_q;
  logic [CNT_W-1:0]    inflight_q;
  logic [CNT_W-1:0]    inflight_d;
  // Responses owed from before the last redirect
  logic [CNT_W-1:0]    stale_q;
  logic                accept;

  // Issue only while the queue can still take the answer
  assign req_valid_o = fetch_en_q & (credit_q < CNT_W'(`FE_QUEUE_DEPTH));
  assign req_o.addr  = pc_q;
  assign accept      = req_valid_o & req_ready_i;

  // Any redirect empties the queue
  assign q_flush_o = be_redirect_i.valid | pd_redirect_i.valid;
  // Responses return in order so stale ones come first
  assign q_drop_o  = rsp_valid_i & (stale_q != '0);

  assign inflight_d = inflight_q + CNT_W'(accept) - CNT_W'(rsp_valid_i);

  //////////////////////////////
  // Program counter

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= PC_INIT;
    end else if (be_redirect_i.valid) begin
      pc_q <= be_redirect_i.pc;
    end else if (pd_redirect_i.valid) begin
      pc_q <= pd_redirect_i.pc;
    end else if (accept) begin
      pc_q <= pc_q + `FE_XLEN'd4;
    end
  end

  //////////////////////////////
  // Credit and stale counters

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q <= 1'b0;
      credit_q   <= '0;
      inflight_q <= '0;
      stale_q    <= '0;
    end else begin
      fetch_en_q <= 1'b1;
      inflight_q <= inflight_d;
      if (q_flush_o) begin
        // Queue is empty now, all in flight words are wrong path
        credit_q <= inflight_d;
        stale_q  <= inflight_d;
      end else begin
        credit_q <= credit_q + CNT_W'(accept) - CNT_W'(q_pop_i) - CNT_W'(q_drop_o);
        stale_q  <= stale_q - CNT_W'(q_drop_o);
      end
    end
  end

  // Queue never overcommitted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CNT_W'(`FE_QUEUE_DEPTH));

endmodule

`default_nettype wire

//--- verilog/fetch_queue.sv
//////////////////////////////
// Fetch queue
// Circular FIFO with drop on write and synchronous clear
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "frontend_cfg.svh"

module fetch_queue #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = `FE_QUEUE_DEPTH
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  logic     drop_i,
  // Write side, no back-pressure
  input  logic     wr_valid_i,
  input  payload_t wr_data_i,
  // Read side
  output payload_t rd_data_o,
  output logic     rd_valid_o,
  input  logic     rd_ready_i
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             wr_en;
  logic             rd_en;

  // Wrap at DEPTH, any size
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_en      = wr_valid_i & ~drop_i;
  assign rd_valid_o = (count_q != '0);
  assign rd_en      = rd_valid_o & rd_ready_i;
  assign rd_data_o  = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  // Pointers and fill level, clear wins over both ports
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

  // Credits upstream keep a full queue from being written
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en |-> count_q != CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- verilog/branch_hist_table.sv
//////////////////////////////
// Branch history table
// 2-bit saturating counters per PC index
// Read by pre-decode, trained by the back end
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "frontend_cfg.svh"

module branch_hist_table (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Lookup from pre-decode
  input  logic [`FE_BHT_IDX_W-1:0]  rd_idx_i,
  output logic [1:0]                rd_cnt_o,
  // Resolve port
  input  frontend_pkg::bht_update_t upd_i
);

  localparam int unsigned ENTRIES = 1 << `FE_BHT_IDX_W;

  // 00 strong not taken up to 11 strong taken
  logic [1:0]               cnt_q [ENTRIES];
  logic [`FE_BHT_IDX_W-1:0] upd_idx;
  logic [1:0]               upd_cnt;
  logic [1:0]               upd_nxt;

  // Combinational lookup
  assign rd_cnt_o = cnt_q[rd_idx_i];

  // Word aligned PCs, skip bits 1:0
  assign upd_idx = upd_i.pc[`FE_BHT_IDX_W+1:2];
  assign upd_cnt = cnt_q[upd_idx];

  //////////////////////////////
  // Saturating step

  always_comb begin
    upd_nxt = upd_cnt;
    if (upd_i.taken) begin
      // Up towards 11
      if (upd_cnt != 2'b11) begin
        upd_nxt = upd_cnt + 2'b01;
      end
    end else begin
      // Down towards 00
      if (upd_cnt != 2'b00) begin
        upd_nxt = upd_cnt - 2'b01;
      end
    end
  end

  //////////////////////////////
  // Counter array

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Weakly not taken
      for (int i = 0; i < ENTRIES; i++) begin
        cnt_q[i] <= 2'b01;
      end
    end else if (upd_i.valid) begin
      cnt_q[upd_idx] <= upd_nxt;
    end
  end

endmodule

`default_nettype wire

//--- verilog/pre_decode.sv
//////////////////////////////
// Instruction pre-decode
// Register and CSR fields, JAL and branch prediction
// Redirects fetch on predicted taken transfers
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "frontend_cfg.svh"

module pre_decode (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  frontend_pkg::redirect_t  be_redirect_i,
  // From fetch queue
  input  frontend_pkg::fetch_rsp_t in_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  // To decode
  output frontend_pkg::pd_out_t    out_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  // History table lookup
  output logic [`FE_BHT_IDX_W-1:0] bht_idx_o,
  input  logic [1:0]               bht_cnt_i,
  // Fetch redirect
  output frontend_pkg::redirect_t  pd_redirect_o
);

  frontend_pkg::instr_t  insn;
  // Raw immediates, bit 0 always zero
  logic [20:0]           imm_j;
  logic [12:0]           imm_b;
  logic [`FE_XLEN-1:0]   ext_imm_j;
  logic [`FE_XLEN-1:0]   ext_imm_b;
  logic [`FE_XLEN-1:0]   target;
  logic                  pred_taken;
  logic [1:0]            pred_bits;
  logic                  take;
  frontend_pkg::pd_out_t out_d;
  frontend_pkg::pd_out_t out_q;
  logic                  out_valid_q;

  //////////////////////////////
  // Handshake

  // Output register free or draining
  assign in_ready_o = ~out_valid_q | out_ready_i;
  assign take       = in_valid_i & in_ready_o;

  // A faulted fetch carries no usable word
  assign insn = in_i.fault ? frontend_pkg::INSTR_NOP : in_i.instr;

  //////////////////////////////
  // Immediates

  // J type
  assign imm_j = {insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  // B type
  assign imm_b = {insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  assign ext_imm_j = {{(`FE_XLEN-21){imm_j[20]}}, imm_j};
  assign ext_imm_b = {{(`FE_XLEN-13){imm_b[12]}}, imm_b};

  //////////////////////////////
  // Prediction

  // Table indexed by the fetch address
  assign bht_idx_o = in_i.addr[`FE_BHT_IDX_W+1:2];

  always_comb begin
    pred_taken = 1'b0;
    pred_bits  = 2'b00;
    target     = in_i.addr + ext_imm_b;
    case (insn[6:0])
      frontend_pkg::OPC_JAL: begin
        // Unconditional, always taken
        pred_taken = 1'b1;
        pred_bits  = 2'b10;
        target     = in_i.addr + ext_imm_j;
      end
      frontend_pkg::OPC_BRANCH: begin
        // Counter MSB decides
        pred_taken = bht_cnt_i[1];
        pred_bits  = bht_cnt_i;
      end
      default: begin
        pred_taken = 1'b0;
      end
    endcase
  end

  // One pulse per accepted jump
  assign pd_redirect_o.valid = take & pred_taken;
  assign pd_redirect_o.pc    = target;

  //////////////////////////////
  // Output register

  always_comb begin
    out_d.pc      = in_i.addr;
    out_d.instr   = insn;
    out_d.rs1     = insn[19:15];
    out_d.rs2     = insn[24:20];
    out_d.csr     = insn[31:20];
    out_d.fault   = in_i.fault;
    out_d.predict = pred_bits;
  end

  // Back-end redirect drops the held instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (be_redirect_i.valid) begin
      out_valid_q <= 1'b0;
    end else if (take) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (take) begin
      out_q <= out_d;
    end
  end

  assign out_o       = out_q;
  assign out_valid_o = out_valid_q;

  // Wrong path words behind a jump are gone one cycle later
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pd_redirect_o.valid |=> !in_valid_i);

endmodule

`default_nettype wire

//--- verilog/frontend_top.sv
//////////////////////////////
// Instruction front end
// PC generator, fetch queue, history table and pre-decode
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "frontend_cfg.svh"

module frontend_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Instruction memory
  output frontend_pkg::fetch_req_t  imem_req_o,
  output logic                      imem_req_valid_o,
  input  logic                      imem_req_ready_i,
  input  frontend_pkg::fetch_rsp_t  imem_rsp_i,
  input  logic                      imem_rsp_valid_i,
  // Back end
  input  frontend_pkg::redirect_t   be_redirect_i,
  input  frontend_pkg::bht_update_t bht_update_i,
  // Decode stream
  output frontend_pkg::pd_out_t     dec_o,
  output logic                      dec_valid_o,
  input  logic                      dec_ready_i
);

  // Queue to pre-decode
  frontend_pkg::fetch_rsp_t q_rsp;
  logic                     q_valid;
  logic                     q_ready;
  logic                     q_pop;
  // Queue control from PC generator
  logic                     q_flush;
  logic                     q_drop;
  // Pre-decode redirect and table lookup
  frontend_pkg::redirect_t  pd_redirect;
  logic [`FE_BHT_IDX_W-1:0] bht_idx;
  logic [1:0]               bht_cnt;

  assign q_pop = q_valid & q_ready;

  fetch_pc_gen u_pc_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .be_redirect_i (be_redirect_i),
    .pd_redirect_i (pd_redirect),
    .req_o         (imem_req_o),
    .req_valid_o   (imem_req_valid_o),
    .req_ready_i   (imem_req_ready_i),
    .rsp_valid_i   (imem_rsp_valid_i),
    .q_pop_i       (q_pop),
    .q_flush_o     (q_flush),
    .q_drop_o      (q_drop)
  );

  fetch_queue #(
    .payload_t (frontend_pkg::fetch_rsp_t),
    .DEPTH     (`FE_QUEUE_DEPTH)
  ) u_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (q_flush),
    .drop_i     (q_drop),
    .wr_valid_i (imem_rsp_valid_i),
    .wr_data_i  (imem_rsp_i),
    .rd_data_o  (q_rsp),
    .rd_valid_o (q_valid),
    .rd_ready_i (q_ready)
  );

  branch_hist_table u_bht (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .rd_idx_i (bht_idx),
    .rd_cnt_o (bht_cnt),
    .upd_i    (bht_update_i)
  );

  pre_decode u_pd (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .be_redirect_i (be_redirect_i),
    .in_i          (q_rsp),
    .in_valid_i    (q_valid),
    .in_ready_o    (q_ready),
    .out_o         (dec_o),
    .out_valid_o   (dec_valid_o),
    .out_ready_i   (dec_ready_i),
    .bht_idx_o     (bht_idx),
    .bht_cnt_i     (bht_cnt),
    .pd_redirect_o (pd_redirect)
  );

endmodule

`default_nettype wire

//--- test/imem_model.sv
//////////////////////////////
// Instruction memory model
// Always ready, answers each request one cycle later
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module imem_model #(
  parameter int unsigned WORDS = 256
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Request side
  input  frontend_pkg::fetch_req_t req_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  // Response side, no back-pressure
  output frontend_pkg::fetch_rsp_t rsp_o,
  output logic                     rsp_valid_o
);

  localparam int unsigned IDX_W = $clog2(WORDS);

  // Word array, filled by the testbench before reset release
  logic [31:0]      mem [WORDS];
  logic [IDX_W-1:0] idx;

  assign req_ready_o = 1'b1;
  // Byte address to word index
  assign idx = req_i.addr[IDX_W+1:2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i & req_ready_o;
    end
  end

  // Response payload
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_o <= '0;
    end else if (req_valid_i) begin
      rsp_o.addr  <= req_i.addr;
      rsp_o.instr <= mem[idx];
      // Outside the array counts as a bus fault
      rsp_o.fault <= (req_i.addr[31:IDX_W+2] != '0);
    end
  end

endmodule

`default_nettype wire

//--- test/tb_frontend.sv
//////////////////////////////
// Front end testbench
// Program image, stimulus steps, expected decode stream
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "frontend_cfg.svh"

module tb_frontend;

  localparam int unsigned WORDS   = 256;
  localparam int unsigned EXP_N   = 24;
  localparam int unsigned STEP_N  = 6;
  localparam int unsigned MAX_CYC = 20 * EXP_N;
  localparam logic [31:0] SEED    = 32'h167e_7d9b;
  localparam logic [31:0] PC0     = `FE_PC_INIT;

  // n is the transfer count to collect, zero for one control cycle
  typedef struct packed {
    logic        redir;
    logic [31:0] redir_pc;
    logic        upd;
    logic [31:0] upd_pc;
    logic        upd_taken;
    logic        rnd_ready;
    logic [7:0]  n;
  } step_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [1:0]  predict;
  } exp_t;

  logic                      clk_i;
  logic                      rst_ni;
  frontend_pkg::fetch_req_t  imem_req;
  logic                      imem_req_valid;
  logic                      imem_req_ready;
  frontend_pkg::fetch_rsp_t  imem_rsp;
  logic                      imem_rsp_valid;
  frontend_pkg::redirect_t   be_redirect;
  frontend_pkg::bht_update_t bht_update;
  frontend_pkg::pd_out_t     dec;
  logic                      dec_valid;
  logic                      dec_ready;

  logic [31:0] image [WORDS];
  exp_t        exp_tab [EXP_N];
  step_t       steps [STEP_N];
  int          exp_n = 0;
  int          seen = 0;
  int          cycles = 0;
  int          pc_errs = 0;
  int          instr_errs = 0;
  int          field_errs = 0;
  int          pred_errs = 0;

  frontend_top UUT (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .imem_req_o       (imem_req),
    .imem_req_valid_o (imem_req_valid),
    .imem_req_ready_i (imem_req_ready),
    .imem_rsp_i       (imem_rsp),
    .imem_rsp_valid_i (imem_rsp_valid),
    .be_redirect_i    (be_redirect),
    .bht_update_i     (bht_update),
    .dec_o            (dec),
    .dec_valid_o      (dec_valid),
    .dec_ready_i      (dec_ready)
  );

  imem_model #(.WORDS(WORDS)) u_imem (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (imem_req),
    .req_valid_i (imem_req_valid),
    .req_ready_o (imem_req_ready),
    .rsp_o       (imem_rsp),
    .rsp_valid_o (imem_rsp_valid)
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////
  // Image and table helpers

  // addi with fields taken from the word index, never a jump
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {4'hA, idx, idx[7:3], 3'b000, idx[4:0], 7'b0010011};
  endfunction

  task automatic place_word(input logic [31:0] pc, input logic [31:0] word);
    image[pc[9:2]] = word;
  endtask

  task automatic expect_next(input logic [31:0] pc, input logic [1:0] predict);
    exp_tab[exp_n] = '{pc, image[pc[9:2]], predict};
    exp_n++;
  endtask

  task automatic apply_step(input step_t st);
    if (st.n == 0) begin
      dec_ready = 1'b0;
    end else if (st.rnd_ready) begin
      // Roughly one gap in four cycles
      dec_ready = (($urandom & 32'd3) != 0);
    end else begin
      dec_ready = 1'b1;
    end
    be_redirect.valid = st.redir;
    be_redirect.pc    = st.redir_pc;
    bht_update.valid  = st.upd;
    bht_update.pc     = st.upd_pc;
    bht_update.taken  = st.upd_taken;
  endtask

  // Field positions from the base instruction formats
  task automatic check_transfer();
    exp_t e;
    e = exp_tab[seen];
    if (dec.pc !== e.pc) begin
      $display("Error at %0t ns: dec_o.pc = %h, expected %h", $time, dec.pc, e.pc);
      pc_errs++;
    end
    if (dec.instr !== e.instr) begin
      $display("Error at %0t ns: dec_o.instr = %h, expected %h", $time, dec.instr, e.instr);
      instr_errs++;
    end
    if (dec.rs1 !== e.instr[19:15]) begin
      $display("Error at %0t ns: dec_o.rs1 = %h, expected %h", $time, dec.rs1, e.instr[19:15]);
      field_errs++;
    end
    if (dec.rs2 !== e.instr[24:20]) begin
      $display("Error at %0t ns: dec_o.rs2 = %h, expected %h", $time, dec.rs2, e.instr[24:20]);
      field_errs++;
    end
    if (dec.csr !== e.instr[31:20]) begin
      $display("Error at %0t ns: dec_o.csr = %h, expected %h", $time, dec.csr, e.instr[31:20]);
      field_errs++;
    end
    if (dec.fault !== 1'b0) begin
      $display("Error at %0t ns: dec_o.fault = %b, expected 0", $time, dec.fault);
      field_errs++;
    end
    if (dec.predict !== e.predict) begin
      $display("Error at %0t ns: dec_o.predict = %b, expected %b", $time, dec.predict, e.predict);
      pred_errs++;
    end
    seen++;
  endtask

  // Cycle limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYC) begin
      $display("Timeout after %0d cycles, only %0d of %0d instructions seen", cycles, seen, EXP_N);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////
  // Main sequence

  initial begin
    int s;
    int got;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    dec_ready   = 1'b0;
    be_redirect = '0;
    bht_update  = '0;
    void'($urandom(SEED));

    // Program over an address-dependent fill
    for (int i = 0; i < WORDS; i++) begin
      image[i] = fill_word(8'(i));
    end
    place_word(PC0 + 'h00, 32'h305110F3);  // csrrw x1, mtvec, x2
    place_word(PC0 + 'h04, 32'h005201B3);  // add x3, x4, x5
    place_word(PC0 + 'h08, 32'h40C58533);  // sub x10, x11, x12
    place_word(PC0 + 'h0C, 32'h020000EF);  // jal x1, +0x20
    place_word(PC0 + 'h2C, 32'h00F766B3);  // or x13, x14, x15
    place_word(PC0 + 'h30, 32'h02628863);  // beq x5, x6, +0x30
    place_word(PC0 + 'h6C, 32'hF95FF0EF);  // jal x1, -0x6c
    for (int i = 0; i < WORDS; i++) begin
      u_imem.mem[i] = image[i];
    end

    // Straight line, jump, untrained branch falls through
    expect_next(PC0 + 'h00, 2'b00);
    expect_next(PC0 + 'h04, 2'b00);
    expect_next(PC0 + 'h08, 2'b00);
    expect_next(PC0 + 'h0C, 2'b10);
    expect_next(PC0 + 'h2C, 2'b00);
    expect_next(PC0 + 'h30, 2'b01);
    expect_next(PC0 + 'h34, 2'b00);
    expect_next(PC0 + 'h38, 2'b00);
    // After training and back-end redirect, branch taken
    expect_next(PC0 + 'h2C, 2'b00);
    expect_next(PC0 + 'h30, 2'b11);
    expect_next(PC0 + 'h60, 2'b00);
    expect_next(PC0 + 'h64, 2'b00);
    // Loop under random ready gaps
    expect_next(PC0 + 'h68, 2'b00);
    expect_next(PC0 + 'h6C, 2'b10);
    expect_next(PC0 + 'h00, 2'b00);
    expect_next(PC0 + 'h04, 2'b00);
    expect_next(PC0 + 'h08, 2'b00);
    expect_next(PC0 + 'h0C, 2'b10);
    expect_next(PC0 + 'h2C, 2'b00);
    expect_next(PC0 + 'h30, 2'b11);
    expect_next(PC0 + 'h60, 2'b00);
    expect_next(PC0 + 'h64, 2'b00);
    expect_next(PC0 + 'h68, 2'b00);
    expect_next(PC0 + 'h6C, 2'b10);

    // redir, redir_pc, upd, upd_pc, taken, rnd_ready, n
    steps[0] = '{1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 8'd8};
    steps[1] = '{1'b0, 32'h0, 1'b1, PC0 + 32'h30, 1'b1, 1'b0, 8'd0};
    steps[2] = '{1'b0, 32'h0, 1'b1, PC0 + 32'h30, 1'b1, 1'b0, 8'd0};
    steps[3] = '{1'b1, PC0 + 32'h2C, 1'b0, 32'h0, 1'b0, 1'b0, 8'd0};
    steps[4] = '{1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 8'd4};
    steps[5] = '{1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b1, 8'd12};

    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // Drive after the edge, sample at the falling edge
    for (s = 0; s < STEP_N; s++) begin
      got = 0;
      do begin
        @(posedge clk_i);
        #1;
        apply_step(steps[s]);
        @(negedge clk_i);
        if (dec_valid && dec_ready) begin
          check_transfer();
          got++;
        end
      end while (got < int'(steps[s].n));
    end

    $display("Checked %0d instructions, errors: pc %0d, instr %0d, fields %0d, predict %0d",
             seen, pc_errs, instr_errs, field_errs, pred_errs);
    if (pc_errs + instr_errs + field_errs + pred_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- frontend.f
+incdir+verilog
verilog/frontend_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_queue.sv
verilog/branch_hist_table.sv
verilog/pre_decode.sv
verilog/frontend_top.sv
test/imem_model.sv
test/tb_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the front end testbench with Verilator, run it and judge the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_frontend -Mdir "$OBJ" -f frontend.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_frontend" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
